//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;
  localparam int NREG = 16;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_IMM    = 7'b0010011,
    OP_OP     = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_SYSTEM = 7'b1110011,
    OP_FENCE  = 7'b0001111
  } opcode_e;

  // {alt bit, funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef enum logic [1:0] {
    K_ALU,
    K_JAL,
    K_JALR,
    K_BRANCH
  } kind_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  typedef struct packed {
    logic [31:0]     inst;
    logic [XLEN-1:0] pc;
  } fetch_t;

  typedef struct packed {
    alu_op_e         alu_op;
    logic            we;
    logic [3:0]      rd;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] rs1_val;  // branch compare / jalr base
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    kind_e           kind;
    logic [2:0]      funct3;
  } issue_t;

  typedef struct packed {
    logic            we;
    logic [3:0]      rd;
    logic [XLEN-1:0] data;
  } wb_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
  } redirect_t;

endpackage

`default_nettype wire

//--- design/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [3:0]      raddr1_i,
  input  logic [3:0]      raddr2_i,
  input  wb_t             wb_i,
  output logic [XLEN-1:0] rdata1_o,
  output logic [XLEN-1:0] rdata2_o
);

  logic [XLEN-1:0] regs [NREG];
  logic            wr_en;

  assign wr_en = wb_i.we && (wb_i.rd != 4'd0);  // x0 stays zero

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // write-through so a released instruction sees the result this cycle
  assign rdata1_o = (wr_en && wb_i.rd == raddr1_i) ? wb_i.data : regs[raddr1_i];
  assign rdata2_o = (wr_en && wb_i.rd == raddr2_i) ? wb_i.data : regs[raddr2_i];

  // x0 reads zero on both ports, forwarded write or not
  x0_const_a: assert property (@(posedge clk) disable iff (rst)
    (raddr1_i != 4'd0 || rdata1_o == '0) && (raddr2_i != 4'd0 || rdata2_o == '0));

endmodule

`default_nettype wire

//--- design/rv_scoreboard.sv
`timescale 1ns/10ps
`default_nettype none

module rv_scoreboard import rv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [3:0] rs1_i,
  input  logic [3:0] rs2_i,
  input  logic       use_rs1_i,
  input  logic       use_rs2_i,
  input  logic       issue_i,
  input  logic [3:0] issue_rd_i,
  input  wb_t        wb_i,
  output logic       stall_o
);

  logic [NREG-1:0] busy_q;
  logic [NREG-1:0] clr_mask;
  logic [NREG-1:0] set_mask;
  logic [NREG-1:0] busy_eff;  // busy after this cycle's writeback

  assign clr_mask = (wb_i.we && wb_i.rd != 4'd0) ? (NREG'(1) << wb_i.rd) : '0;
  assign set_mask = (issue_i && issue_rd_i != 4'd0) ? (NREG'(1) << issue_rd_i) : '0;
  assign busy_eff = busy_q & ~clr_mask;

  assign stall_o = (use_rs1_i && busy_eff[rs1_i]) || (use_rs2_i && busy_eff[rs2_i]);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_eff | set_mask;
    end
  end

  // one result in flight at most, so rd can never already be pending
  no_double_set_a: assert property (@(posedge clk) disable iff (rst)
    (issue_i && issue_rd_i != 4'd0) |-> !busy_eff[issue_rd_i]);

endmodule

`default_nettype wire

//--- design/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            fetch_valid_i,
  input  fetch_t          fetch_i,
  output logic            fetch_ready_o,
  input  logic [XLEN-1:0] rdata1_i,
  input  logic [XLEN-1:0] rdata2_i,
  output logic [3:0]      raddr1_o,
  output logic [3:0]      raddr2_o,
  input  logic            stall_i,
  output logic            use_rs1_o,
  output logic            use_rs2_o,
  output logic            issue_valid_o,
  output issue_t          issue_o,
  output logic            illegal_o
);

  inst_u           inst_q;
  logic [XLEN-1:0] pc_q;
  logic            valid_q;
  logic            legal;
  logic            leave;
  logic            accept;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  issue_t          iss;

  assign leave         = valid_q && (!legal || !stall_i);  // illegal words drop out
  assign fetch_ready_o = !valid_q || leave;
  assign accept        = fetch_valid_i && fetch_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (leave) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= fetch_i.inst;
      pc_q   <= fetch_i.pc;
    end
  end

  assign imm_i = {{20{inst_q.i.imm[11]}}, inst_q.i.imm};
  assign imm_b = {{20{inst_q.b.imm12}}, inst_q.b.imm11, inst_q.b.imm10_5,
                  inst_q.b.imm4_1, 1'b0};
  assign imm_u = {inst_q.u.imm, 12'd0};
  assign imm_j = {{12{inst_q.j.imm20}}, inst_q.j.imm19_12, inst_q.j.imm11,
                  inst_q.j.imm10_1, 1'b0};

  // rv32e: upper index bit ignored
  assign raddr1_o = inst_q.r.rs1[3:0];
  assign raddr2_o = inst_q.r.rs2[3:0];

  always_comb begin
    iss         = '0;
    iss.alu_op  = ALU_ADD;
    iss.kind    = K_ALU;
    iss.rd      = inst_q.r.rd[3:0];
    iss.funct3  = inst_q.r.funct3;
    iss.pc      = pc_q;
    iss.rs1_val = rdata1_i;
    iss.rs2_val = rdata2_i;
    legal       = 1'b1;
    use_rs1_o   = 1'b0;
    use_rs2_o   = 1'b0;
    case (inst_q.r.opcode)
      OP_LUI, OP_AUIPC: begin
        iss.we  = 1'b1;
        iss.imm = imm_u;
        iss.op1 = (inst_q.r.opcode == OP_AUIPC) ? pc_q : '0;
        iss.op2 = imm_u;
      end
      OP_JAL, OP_JALR: begin  // link value pc + 4
        iss.we    = 1'b1;
        iss.op1   = pc_q;
        iss.op2   = XLEN'(4);
        iss.kind  = (inst_q.r.opcode == OP_JAL) ? K_JAL : K_JALR;
        iss.imm   = (inst_q.r.opcode == OP_JAL) ? imm_j : imm_i;
        use_rs1_o = (inst_q.r.opcode == OP_JALR);
      end
      OP_BRANCH: begin
        iss.kind  = K_BRANCH;
        iss.imm   = imm_b;
        iss.op1   = rdata1_i;
        iss.op2   = rdata2_i;
        use_rs1_o = 1'b1;
        use_rs2_o = 1'b1;
      end
      OP_IMM: begin
        iss.we     = 1'b1;
        iss.imm    = imm_i;
        iss.op1    = rdata1_i;
        iss.op2    = imm_i;
        iss.alu_op = alu_op_e'({(inst_q.r.funct3 == 3'b101) & inst_q.r.funct7[5],
                                inst_q.r.funct3});  // srai only
        use_rs1_o  = 1'b1;
      end
      OP_OP: begin
        iss.we     = 1'b1;
        iss.op1    = rdata1_i;
        iss.op2    = rdata2_i;
        iss.alu_op = alu_op_e'({inst_q.r.funct7[5], inst_q.r.funct3});
        use_rs1_o  = 1'b1;
        use_rs2_o  = 1'b1;
      end
      default: legal = 1'b0;
    endcase
  end

  assign issue_valid_o = valid_q && legal && !stall_i;
  assign issue_o       = iss;
  assign illegal_o     = valid_q && !legal;

  fetch_hold_a: assert property (@(posedge clk) disable iff (rst)
    (fetch_valid_i && !fetch_ready_o) |=> $stable(fetch_i));

endmodule

`default_nettype wire

//--- design/rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      issue_valid_i,
  input  issue_t    issue_i,
  output wb_t       wb_o,
  output redirect_t redirect_o
);

  logic [XLEN-1:0] alu_res;
  logic [4:0]      shamt;
  logic            taken;
  logic [XLEN-1:0] target;
  logic            wb_we_q;
  logic [3:0]      wb_rd_q;
  logic [XLEN-1:0] wb_data_q;
  logic            redir_valid_q;
  logic [XLEN-1:0] redir_pc_q;

  assign shamt = issue_i.op2[4:0];

  always_comb begin
    case (issue_i.alu_op)
      ALU_ADD:  alu_res = issue_i.op1 + issue_i.op2;
      ALU_SUB:  alu_res = issue_i.op1 - issue_i.op2;
      ALU_SLL:  alu_res = issue_i.op1 << shamt;
      ALU_SLT:  alu_res = XLEN'($signed(issue_i.op1) < $signed(issue_i.op2));
      ALU_SLTU: alu_res = XLEN'(issue_i.op1 < issue_i.op2);
      ALU_XOR:  alu_res = issue_i.op1 ^ issue_i.op2;
      ALU_SRL:  alu_res = issue_i.op1 >> shamt;
      ALU_SRA:  alu_res = $unsigned($signed(issue_i.op1) >>> shamt);
      ALU_OR:   alu_res = issue_i.op1 | issue_i.op2;
      ALU_AND:  alu_res = issue_i.op1 & issue_i.op2;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (issue_i.funct3)
      3'b000:  taken = issue_i.rs1_val == issue_i.rs2_val;
      3'b001:  taken = issue_i.rs1_val != issue_i.rs2_val;
      3'b100:  taken = $signed(issue_i.rs1_val) < $signed(issue_i.rs2_val);
      3'b101:  taken = $signed(issue_i.rs1_val) >= $signed(issue_i.rs2_val);
      3'b110:  taken = issue_i.rs1_val < issue_i.rs2_val;
      3'b111:  taken = issue_i.rs1_val >= issue_i.rs2_val;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (issue_i.kind)
      K_JAL:    target = issue_i.pc + issue_i.imm;
      K_JALR:   target = (issue_i.rs1_val + issue_i.imm) & ~XLEN'(1);
      K_BRANCH: target = taken ? issue_i.pc + issue_i.imm : issue_i.pc + XLEN'(4);
      default:  target = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_we_q       <= 1'b0;
      redir_valid_q <= 1'b0;
    end else begin
      wb_we_q       <= issue_valid_i && issue_i.we;
      redir_valid_q <= issue_valid_i && (issue_i.kind != K_ALU);  // every branch reports
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_q    <= issue_i.rd;
    wb_data_q  <= alu_res;
    redir_pc_q <= target;
  end

  assign wb_o       = '{we: wb_we_q, rd: wb_rd_q, data: wb_data_q};
  assign redirect_o = '{valid: redir_valid_q, pc: redir_pc_q};

endmodule

`default_nettype wire

//--- design/rv_int_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module rv_int_pipe import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      fetch_valid_i,
  input  fetch_t    fetch_i,
  output logic      fetch_ready_o,
  output wb_t       wb_o,
  output redirect_t redirect_o,
  output logic      illegal_o
);

  logic [3:0]      raddr1;
  logic [3:0]      raddr2;
  logic [XLEN-1:0] rdata1;
  logic [XLEN-1:0] rdata2;
  logic            use_rs1;
  logic            use_rs2;
  logic            stall;
  logic            issue_valid;
  issue_t          issue;

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .wb_i     (wb_o),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  rv_scoreboard u_scoreboard (
    .clk        (clk),
    .rst        (rst),
    .rs1_i      (raddr1),
    .rs2_i      (raddr2),
    .use_rs1_i  (use_rs1),
    .use_rs2_i  (use_rs2),
    .issue_i    (issue_valid && issue.we),  // only writers mark rd busy
    .issue_rd_i (issue.rd),
    .wb_i       (wb_o),
    .stall_o    (stall)
  );

  rv_decode u_decode (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_i       (fetch_i),
    .fetch_ready_o (fetch_ready_o),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .raddr1_o      (raddr1),
    .raddr2_o      (raddr2),
    .stall_i       (stall),
    .use_rs1_o     (use_rs1),
    .use_rs2_o     (use_rs2),
    .issue_valid_o (issue_valid),
    .issue_o       (issue),
    .illegal_o     (illegal_o)
  );

  rv_execute u_execute (
    .clk           (clk),
    .rst           (rst),
    .issue_valid_i (issue_valid),
    .issue_i       (issue),
    .wb_o          (wb_o),
    .redirect_o    (redirect_o)
  );

endmodule

`default_nettype wire

//--- tests/rv_int_pipe_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_int_pipe_tb import rv_pkg::*; ();

  logic      clk = 1'b0;
  logic      rst;
  logic      fetch_valid_i;
  fetch_t    fetch_i;
  logic      fetch_ready_o;
  wb_t       wb_o;
  redirect_t redirect_o;
  logic      illegal_o;

  logic [31:0] model [16];  // reference register file
  logic [31:0] pc;
  logic [31:0] rng_state = 32'h323e1ba8;
  wb_t         exp_wb[$];
  wb_t         act_wb[$];
  logic [31:0] exp_tgt[$];
  logic [31:0] act_tgt[$];
  int          exp_illegal = 0;
  int          act_illegal = 0;
  int          checks = 0;
  int          errors = 0;
  int          err_mark;
  string       cur_test;

  rv_int_pipe u_dut (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_i       (fetch_i),
    .fetch_ready_o (fetch_ready_o),
    .wb_o          (wb_o),
    .redirect_o    (redirect_o),
    .illegal_o     (illegal_o)
  );

  always #50 clk = ~clk;

  // outputs come from registers, so mid-cycle they are settled
  always @(negedge clk) begin
    if (!rst) begin
      if (wb_o.we) act_wb.push_back(wb_o);
      if (redirect_o.valid) act_tgt.push_back(redirect_o.pc);
      if (illegal_o) act_illegal++;
    end
  end

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return (sa < sb) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return sa >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic taken_ref(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return sa < sb;
      3'd5: return sa >= sb;
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [3:0] rs2,
                                        input logic [3:0] rs1, input logic [2:0] f3,
                                        input logic [3:0] rd, input logic [6:0] opc);
    return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [3:0] rs1,
                                        input logic [2:0] f3, input logic [3:0] rd,
                                        input logic [6:0] opc);
    return {imm, 1'b0, rs1, f3, 1'b0, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [3:0] rs2,
                                        input logic [3:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], 1'b0, rs2, 1'b0, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [3:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 1'b0, rd, OP_JAL};
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic offer(input logic [31:0] word);
    fetch_valid_i = 1'b1;
    fetch_i       = '{inst: word, pc: pc};
    while (!fetch_ready_o) @(negedge clk);
    @(negedge clk);
    fetch_valid_i = 1'b0;
  endtask

  task automatic expect_wb(input logic [3:0] rd, input logic [31:0] data);
    exp_wb.push_back(wb_t'{we: 1'b1, rd: rd, data: data});
    if (rd != 4'd0) model[rd] = data;
  endtask

  task automatic run_op(input logic [2:0] f3, input logic alt, input logic [3:0] rd,
                        input logic [3:0] rs1, input logic [3:0] rs2);
    logic [31:0] res;
    res = alu_ref(f3, alt, model[rs1], model[rs2]);
    expect_wb(rd, res);
    offer(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OP_OP));
    pc += 4;
  endtask

  task automatic run_imm(input logic [2:0] f3, input logic alt, input logic [3:0] rd,
                         input logic [3:0] rs1, input logic [11:0] raw);
    logic [11:0] imm;
    logic        sra;
    sra = alt && f3 == 3'd5;
    imm = (f3 == 3'd1 || f3 == 3'd5) ? {sra ? 7'h20 : 7'h00, raw[4:0]} : raw;
    expect_wb(rd, alu_ref(f3, sra, model[rs1], sext12(imm)));
    offer(enc_i(imm, rs1, f3, rd, OP_IMM));
    pc += 4;
  endtask

  task automatic run_upper(input logic auipc, input logic [3:0] rd, input logic [19:0] imm);
    expect_wb(rd, {imm, 12'd0} + (auipc ? pc : 32'd0));
    offer({imm, 1'b0, rd, auipc ? OP_AUIPC : OP_LUI});
    pc += 4;
  endtask

  // the feeder waits for each redirect, since nothing younger is squashed
  task automatic run_jal(input logic [3:0] rd, input logic [20:0] imm);
    logic [31:0] tgt;
    tgt = pc + {{11{imm[20]}}, imm};
    expect_wb(rd, pc + 32'd4);
    exp_tgt.push_back(tgt);
    offer(enc_j(imm, rd));
    wait_results();
    pc = tgt;
  endtask

  task automatic run_jalr(input logic [3:0] rd, input logic [3:0] rs1, input logic [11:0] imm);
    logic [31:0] tgt;
    tgt = (model[rs1] + sext12(imm)) & ~32'd1;  // base read before the link write
    expect_wb(rd, pc + 32'd4);
    exp_tgt.push_back(tgt);
    offer(enc_i(imm, rs1, 3'd0, rd, OP_JALR));
    wait_results();
    pc = tgt;
  endtask

  task automatic run_branch(input logic [2:0] f3, input logic [3:0] rs1, input logic [3:0] rs2,
                            input logic [12:0] imm);
    logic [31:0] tgt;
    tgt = taken_ref(f3, model[rs1], model[rs2]) ? pc + {{19{imm[12]}}, imm} : pc + 32'd4;
    exp_tgt.push_back(tgt);
    offer(enc_b(imm, rs2, rs1, f3));
    wait_results();
    pc = tgt;
  endtask

  task automatic run_illegal(input logic [31:0] word);
    exp_illegal++;
    offer(word);
    pc += 4;
  endtask

  task automatic wait_results();
    int n;
    n = 0;
    @(posedge clk);
    while ((act_wb.size() < exp_wb.size() || act_tgt.size() < exp_tgt.size() ||
            act_illegal < exp_illegal) && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (n >= 200) begin
      errors++;
      $display("%s: expected results did not arrive within 200 cycles", cur_test);
    end
    @(negedge clk);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic finish_test();
    wait_results();
    repeat (4) @(posedge clk);  // room for any stray record
    check("writeback count", exp_wb.size(), act_wb.size());
    check("redirect count", exp_tgt.size(), act_tgt.size());
    check("illegal count", exp_illegal, act_illegal);
    for (int i = 0; i < exp_wb.size() && i < act_wb.size(); i++) begin
      check($sformatf("wb %0d rd", i), exp_wb[i].rd, act_wb[i].rd);
      check($sformatf("wb %0d data", i), exp_wb[i].data, act_wb[i].data);
    end
    for (int i = 0; i < exp_tgt.size() && i < act_tgt.size(); i++) begin
      check($sformatf("target %0d", i), exp_tgt[i], act_tgt[i]);
    end
    if (errors == err_mark) $display("test %s: ok", cur_test);
    else $display("test %s: %0d errors", cur_test, errors - err_mark);
    exp_wb.delete();
    act_wb.delete();
    exp_tgt.delete();
    act_tgt.delete();
    exp_illegal = 0;
    act_illegal = 0;
    @(negedge clk);
  endtask

  task automatic apply_reset();
    rst           = 1'b1;
    fetch_valid_i = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < 16; i++) model[i] = '0;
    pc = 32'h0000_1000;
  endtask

  task automatic test_alu();
    logic [31:0] v;
    start_test("alu_ops");
    for (int r = 1; r < 8; r++) begin
      v = rand32();
      run_upper(1'b0, 4'(r), v[31:12]);
      run_imm(3'd0, 1'b0, 4'(r), 4'(r), v[11:0]);
    end
    for (int k = 0; k < 8; k++) begin
      v = rand32();
      run_op(k[2:0], 1'b0, 4'(8 + k), 4'(1 + v[2:0] % 7), 4'(1 + v[5:3] % 7));
    end
    run_op(3'd0, 1'b1, 4'd14, 4'd1, 4'd2);  // sub
    run_op(3'd5, 1'b1, 4'd15, 4'd3, 4'd4);  // sra
    for (int k = 0; k < 8; k++) begin
      v = rand32();
      run_imm(k[2:0], 1'b0, 4'(8 + k), 4'(1 + v[2:0] % 7), v[31:20]);
    end
    v = rand32();
    run_imm(3'd5, 1'b1, 4'd13, 4'd2, v[11:0]);
    run_op(3'd0, 1'b0, 4'd0, 4'd1, 4'd2);  // result must not land in x0
    run_op(3'd0, 1'b0, 4'd9, 4'd0, 4'd0);
    finish_test();
  endtask

  task automatic test_deps();
    logic [31:0] v;
    logic [3:0]  prev;
    start_test("dependencies");
    v = rand32();
    run_upper(1'b0, 4'd1, v[31:12]);
    prev = 4'd1;
    for (int k = 0; k < 12; k++) begin
      v = rand32();
      if (k % 2 == 0) run_op(v[2:0], v[3] && (v[2:0] == 3'd0 || v[2:0] == 3'd5),
                             4'(2 + k), prev, 4'd1);
      else run_imm(v[2:0], v[3], 4'(2 + k), prev, v[31:20]);
      prev = 4'(2 + k);
    end
    finish_test();
  endtask

  task automatic test_jumps();
    start_test("upper_jumps");
    run_upper(1'b0, 4'd1, 20'h12345);
    run_upper(1'b1, 4'd2, 20'hfffff);
    run_jal(4'd3, 21'h000040);
    run_jal(4'd0, 21'h1ffff8);  // backward
    run_jalr(4'd4, 4'd1, 12'h7f3);  // odd sum, bit 0 cleared
    run_jalr(4'd1, 4'd1, 12'hff0);
    finish_test();
  endtask

  task automatic test_branches();
    logic [2:0] f3;
    start_test("branches");
    run_imm(3'd0, 1'b0, 4'd1, 4'd0, 12'hffb);  // -5, large when unsigned
    run_imm(3'd0, 1'b0, 4'd2, 4'd0, 12'h003);
    for (int c = 0; c < 6; c++) begin
      f3 = (c < 2) ? 3'(c) : 3'(c + 2);
      for (int p = 0; p < 3; p++) begin
        run_branch(f3, (p == 1) ? 4'd1 : 4'd2, (p == 2) ? 4'd1 : 4'd2,
                   (p == 1) ? 13'h1ff0 : 13'h0040);
      end
    end
    finish_test();
  endtask

  task automatic test_illegal();
    start_test("illegal_ops");
    run_illegal(enc_i(12'h010, 4'd1, 3'd2, 4'd5, OP_LOAD));
    run_illegal(enc_r(7'h00, 4'd2, 4'd1, 3'd2, 4'd4, OP_STORE));
    run_illegal(32'h0000_0073);  // ecall
    run_imm(3'd0, 1'b0, 4'd5, 4'd0, 12'h04d);
    finish_test();
  endtask

  task automatic test_reset();
    start_test("reset_state");
    apply_reset();
    check("fetch ready", 32'd1, 32'(fetch_ready_o));
    for (int i = 0; i < 16; i++) begin
      run_op(3'd0, 1'b0, 4'(i), 4'(i), 4'd0);
    end
    finish_test();
  endtask

  initial begin
    rst           = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_i       = '0;
    apply_reset();
    test_alu();
    test_deps();
    test_jumps();
    test_branches();
    test_illegal();
    test_reset();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // 94 instructions at 20 cycles each, plus two resets
  initial begin
    #((94 * 20 + 2 * 16) * 100);
    $display("watchdog expired before all tests completed");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_scoreboard.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_int_pipe.sv
tests/rv_int_pipe_tb.sv

//--- Bender.yml
package:
  name: rv_int_pipe

sources:
  - files:
      - design/rv_pkg.sv
      - design/rv_regfile.sv
      - design/rv_scoreboard.sv
      - design/rv_decode.sv
      - design/rv_execute.sv
      - design/rv_int_pipe.sv
  - target: test
    files:
      - tests/rv_int_pipe_tb.sv
